// File: src/ring_pkg.sv
// Ring channel shared definitions
// Bus widths, Wishbone classic request and response structs, the host
// configuration and status structs, and the FSM state encodings

package ring_pkg;

    // ==============================
    // Widths
    // ==============================

    // Word address width, enough for 4096 words
    localparam int addr_w = 12;

    // Memory word and stream word width
    localparam int data_w = 32;

    // ==============================
    // Wishbone classic
    // ==============================

    // Master side of a link, held stable from cyc rising until ack
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [addr_w-1:0] adr;
        logic [data_w-1:0] dat_w;
    } wb_req_t;

    // Slave side of a link, read data is valid together with ack
    typedef struct packed {
        logic              ack;
        logic [data_w-1:0] dat_r;
    } wb_rsp_t;

    // ==============================
    // Host configuration and status
    // ==============================

    // Ring bases plus the indices owned by the host
    // Only the low index bits matter to the ring logic
    typedef struct packed {
        logic [addr_w-1:0] in_base;
        logic [addr_w-1:0] out_base;
        logic [7:0]        in_newest;
        logic [7:0]        out_oldest;
    } ring_cfg_t;

    // Indices owned by the device side
    typedef struct packed {
        logic [7:0] in_oldest;
        logic [7:0] out_newest;
    } ring_status_t;

    // Reader FSM states
    typedef enum logic {rd_idle, rd_fetch} rd_state_e;

    // Writer FSM states
    typedef enum logic {wr_idle, wr_store} wr_state_e;

endpackage

// File: src/ring_reader.sv
// Inbound ring reader
// Fetches lines the host has produced into the inbound ring, queues up to
// two of them and streams them out in order, reporting the consumed index

`timescale 1ns/10ps

module ring_reader
  #(
    parameter int ring_idx_bits = 4
    )
   (
    input  logic                            clk,
    input  logic                            reset,
    input  ring_pkg::ring_cfg_t             cfg,
    output ring_pkg::wb_req_t               bus_req,
    input  ring_pkg::wb_rsp_t               bus_rsp,
    output logic [ring_pkg::data_w-1:0]     rx_data,
    output logic                            rx_valid,
    input  logic                            rx_ready,
    output logic [ring_idx_bits-1:0]        in_oldest
    );

    ring_pkg::rd_state_e state;

    // Next slot to fetch from memory
    logic [ring_idx_bits-1:0] fetch_idx;

    // Host's produced index, cut down to the ring size
    logic [ring_idx_bits-1:0] newest_idx;
    assign newest_idx = cfg.in_newest[ring_idx_bits-1:0];

    // ==============================
    // Output queue
    // ==============================

    // Two entries are enough to keep the stream busy with one fetch in
    // flight, and bound how far the reader runs ahead under back-pressure
    logic [ring_pkg::data_w-1:0] q_data [2];
    logic                        q_wr_ptr;
    logic                        q_rd_ptr;
    logic [1:0]                  q_count;

    logic push;
    logic pop;

    // A word enters the queue on the ack of our own read cycle
    assign push = (state == ring_pkg::rd_fetch) && bus_rsp.ack;
    assign pop  = rx_valid && rx_ready;

    assign rx_valid = (q_count != 2'd0);
    assign rx_data  = q_data[q_rd_ptr];

    // Payload storage
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            q_data[q_wr_ptr] <= bus_rsp.dat_r;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            q_wr_ptr <= 1'b0;
            q_rd_ptr <= 1'b0;
            q_count  <= 2'd0;
        end
        else
        begin
            if (push)
                q_wr_ptr <= ~q_wr_ptr;
            if (pop)
                q_rd_ptr <= ~q_rd_ptr;

            // Count moves only when exactly one side is active
            if (push && !pop)
                q_count <= q_count + 2'd1;
            else if (pop && !push)
                q_count <= q_count - 2'd1;
        end
    end

    // ==============================
    // Fetch control
    // ==============================

    // Data is pending while the fetch index trails the host's index
    logic want_fetch;
    assign want_fetch = (fetch_idx != newest_idx) && (q_count < 2'd2);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= ring_pkg::rd_idle;
            fetch_idx <= '0;
        end
        else
        begin
            case (state)
                ring_pkg::rd_idle:
                begin
                    if (want_fetch)
                        state <= ring_pkg::rd_fetch;
                end
                ring_pkg::rd_fetch:
                begin
                    // Drop cyc after the ack so the arbiter can move on
                    if (bus_rsp.ack)
                    begin
                        state     <= ring_pkg::rd_idle;
                        fetch_idx <= fetch_idx + 1'b1;
                    end
                end
                default:
                    state <= ring_pkg::rd_idle;
            endcase
        end
    end

    // Read cycle at base plus index, so the ring needs no alignment
    always_comb
    begin
        bus_req.cyc   = (state == ring_pkg::rd_fetch);
        bus_req.stb   = (state == ring_pkg::rd_fetch);
        bus_req.we    = 1'b0;
        bus_req.adr   = cfg.in_base + ring_pkg::addr_w'(fetch_idx);
        bus_req.dat_w = '0;
    end

    // Consumed index follows words leaving on rx
    always_ff @(posedge clk)
    begin
        if (reset)
            in_oldest <= '0;
        else if (pop)
            in_oldest <= in_oldest + 1'b1;
    end

endmodule

// File: src/ring_writer.sv
// Outbound ring writer
// Accepts device stream words and stores them into the outbound ring,
// publishing its produced index and holding off while the ring is full

`timescale 1ns/10ps

module ring_writer
  #(
    parameter int ring_idx_bits = 4
    )
   (
    input  logic                            clk,
    input  logic                            reset,
    input  ring_pkg::ring_cfg_t             cfg,
    output ring_pkg::wb_req_t               bus_req,
    input  ring_pkg::wb_rsp_t               bus_rsp,
    input  logic [ring_pkg::data_w-1:0]     tx_data,
    input  logic                            tx_valid,
    output logic                            tx_ready,
    output logic [ring_idx_bits-1:0]        out_newest
    );

    ring_pkg::wr_state_e state;

    // Word held for the duration of the write cycle
    logic [ring_pkg::data_w-1:0] hold_data;

    // Host's consumed index, cut down to the ring size
    logic [ring_idx_bits-1:0] oldest_idx;
    assign oldest_idx = cfg.out_oldest[ring_idx_bits-1:0];

    // ==============================
    // Free space
    // ==============================

    // One slot always stays empty so full and empty differ
    // Wrap comes for free from the index width
    logic [ring_idx_bits-1:0] next_idx;
    logic                     ring_full;

    assign next_idx  = out_newest + 1'b1;
    assign ring_full = (next_idx == oldest_idx);

    // Ready only while idle with room in the ring
    assign tx_ready = (state == ring_pkg::wr_idle) && !ring_full;

    logic accept;
    assign accept = tx_valid && tx_ready;

    // Payload capture
    always_ff @(posedge clk)
    begin
        if (accept)
            hold_data <= tx_data;
    end

    // ==============================
    // Store FSM
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ring_pkg::wr_idle;
            out_newest <= '0;
        end
        else
        begin
            case (state)
                ring_pkg::wr_idle:
                begin
                    if (accept)
                        state <= ring_pkg::wr_store;
                end
                ring_pkg::wr_store:
                begin
                    // The slot is only published once memory has the data
                    if (bus_rsp.ack)
                    begin
                        state      <= ring_pkg::wr_idle;
                        out_newest <= next_idx;
                    end
                end
                default:
                    state <= ring_pkg::wr_idle;
            endcase
        end
    end

    // Write cycle at base plus the produced index
    always_comb
    begin
        bus_req.cyc   = (state == ring_pkg::wr_store);
        bus_req.stb   = (state == ring_pkg::wr_store);
        bus_req.we    = 1'b1;
        bus_req.adr   = cfg.out_base + ring_pkg::addr_w'(out_newest);
        bus_req.dat_w = hold_data;
    end

endmodule

// File: src/mem_arbiter.sv
// Round-robin Wishbone classic arbiter
// Shares one memory slave among several masters, granting the bus only
// between cycles and keeping it with the owner while its cyc is high

`timescale 1ns/10ps

module mem_arbiter
  #(
    parameter int n_masters = 3
    )
   (
    input  logic              clk,
    input  logic              reset,
    input  ring_pkg::wb_req_t m_req [n_masters],
    output ring_pkg::wb_rsp_t m_rsp [n_masters],
    output ring_pkg::wb_req_t s_req,
    input  ring_pkg::wb_rsp_t s_rsp
    );

    localparam int sel_w = (n_masters > 1) ? $clog2(n_masters) : 1;

    // Current or most recent owner, and whether a cycle is in progress
    logic [sel_w-1:0] owner;
    logic             busy;

    logic [sel_w-1:0] grant_idx;
    logic             grant_valid;

    // Search starts one past the previous owner for fairness
    always_comb
    begin
        int unsigned cand;
        grant_valid = 1'b0;
        grant_idx   = owner;
        for (int k = 1; k <= n_masters; k++)
        begin
            cand = (int'(owner) + k) % n_masters;
            if (!grant_valid && m_req[cand].cyc)
            begin
                grant_valid = 1'b1;
                grant_idx   = sel_w'(cand);
            end
        end
    end

    // Owner changes only while the bus is idle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy  <= 1'b0;
            owner <= sel_w'(n_masters - 1);
        end
        else if (!busy)
        begin
            if (grant_valid)
            begin
                busy  <= 1'b1;
                owner <= grant_idx;
            end
        end
        else if (!m_req[owner].cyc)
        begin
            busy <= 1'b0;
        end
    end

    // ==============================
    // Routing
    // ==============================

    always_comb
    begin
        s_req = '0;
        if (busy)
            s_req = m_req[owner];
    end

    // Ack reaches the owner alone, read data is shared
    for (genvar i = 0; i < n_masters; i++)
    begin : g_rsp
        assign m_rsp[i].ack   = busy && (owner == sel_w'(i)) && s_rsp.ack;
        assign m_rsp[i].dat_r = s_rsp.dat_r;
    end

endmodule

// File: src/shared_mem.sv
// Shared word memory
// Single-port Wishbone classic slave with a registered one-cycle ack

`timescale 1ns/10ps

module shared_mem
  #(
    parameter int mem_words = 4096
    )
   (
    input  logic              clk,
    input  logic              reset,
    input  ring_pkg::wb_req_t bus_req,
    output ring_pkg::wb_rsp_t bus_rsp
    );

    localparam int mem_aw = (mem_words > 1) ? $clog2(mem_words) : 1;

    logic [ring_pkg::data_w-1:0] mem [mem_words];
    logic [ring_pkg::data_w-1:0] rd_data;
    logic                        ack;

    // A new strobe is one we have not yet acknowledged
    logic access;
    assign access = bus_req.cyc && bus_req.stb && !ack;

    // Ack is one cycle wide, the master still holds stb during it
    always_ff @(posedge clk)
    begin
        if (reset)
            ack <= 1'b0;
        else
            ack <= access;
    end

    // Write lands and read data is captured on the edge that raises ack
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            if (bus_req.we)
                mem[bus_req.adr[mem_aw-1:0]] <= bus_req.dat_w;
            else
                rd_data <= mem[bus_req.adr[mem_aw-1:0]];
        end
    end

    assign bus_rsp.ack   = ack;
    assign bus_rsp.dat_r = rd_data;

endmodule

// File: src/ring_channel_top.sv
// Ring channel top level
// Host port, inbound ring reader and outbound ring writer sharing one
// memory through a round-robin arbiter

`timescale 1ns/10ps

module ring_channel_top
  #(
    parameter int ring_idx_bits = 4,
    parameter int mem_words     = 4096
    )
   (
    input  logic                        clk,
    input  logic                        reset,
    input  ring_pkg::wb_req_t           host_req,
    output ring_pkg::wb_rsp_t           host_rsp,
    input  ring_pkg::ring_cfg_t         cfg,
    output ring_pkg::ring_status_t      status,
    output logic [ring_pkg::data_w-1:0] rx_data,
    output logic                        rx_valid,
    input  logic                        rx_ready,
    input  logic [ring_pkg::data_w-1:0] tx_data,
    input  logic                        tx_valid,
    output logic                        tx_ready
    );

    // Port 0 host, port 1 reader, port 2 writer
    localparam int n_masters = 3;

    ring_pkg::wb_req_t m_req [n_masters];
    ring_pkg::wb_rsp_t m_rsp [n_masters];
    ring_pkg::wb_req_t mem_req;
    ring_pkg::wb_rsp_t mem_rsp;

    logic [ring_idx_bits-1:0] in_oldest;
    logic [ring_idx_bits-1:0] out_newest;

    assign m_req[0] = host_req;
    assign host_rsp = m_rsp[0];

    // Status indices are zero-extended to the host's field width
    assign status.in_oldest  = 8'(in_oldest);
    assign status.out_newest = 8'(out_newest);

    ring_reader #(.ring_idx_bits(ring_idx_bits)) u_reader
        (.clk, .reset, .cfg, .bus_req(m_req[1]), .bus_rsp(m_rsp[1]),
         .rx_data, .rx_valid, .rx_ready, .in_oldest);

    ring_writer #(.ring_idx_bits(ring_idx_bits)) u_writer
        (.clk, .reset, .cfg, .bus_req(m_req[2]), .bus_rsp(m_rsp[2]),
         .tx_data, .tx_valid, .tx_ready, .out_newest);

    mem_arbiter #(.n_masters(n_masters)) u_arb
        (.clk, .reset, .m_req, .m_rsp, .s_req(mem_req), .s_rsp(mem_rsp));

    shared_mem #(.mem_words(mem_words)) u_mem
        (.clk, .reset, .bus_req(mem_req), .bus_rsp(mem_rsp));

endmodule

// File: verification/ring_channel_asserts.sv
// Ring channel bus and index assertions
// Bound into the top level to watch the shared memory bus, the per-master
// acks and the ring indices of the reader and the writer

`timescale 1ns/10ps

module ring_channel_asserts
  #(
    parameter int ring_idx_bits = 4
    )
   (
    input logic                     clk,
    input logic                     reset,
    input ring_pkg::wb_req_t        mem_req,
    input ring_pkg::wb_rsp_t        mem_rsp,
    input ring_pkg::wb_req_t        m_req [3],
    input ring_pkg::wb_rsp_t        m_rsp [3],
    input ring_pkg::ring_cfg_t      cfg,
    input logic [ring_idx_bits-1:0] fetch_idx,
    input logic [ring_idx_bits-1:0] out_newest
    );

    // Number of assertion failures seen so far
    int fail_count = 0;

    // Memory only answers a live strobe
    ack_needs_strobe: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.ack |-> mem_req.cyc && mem_req.stb)
    else
    begin
        $error("memory ack seen without cyc and stb");
        fail_count++;
    end

    // The arbiter routes ack to a single master that still holds its strobe
    ack_one_master: assert property (@(posedge clk) disable iff (reset)
        $onehot0({m_rsp[0].ack, m_rsp[1].ack, m_rsp[2].ack}) &&
        (!m_rsp[0].ack || (m_req[0].cyc && m_req[0].stb)) &&
        (!m_rsp[1].ack || (m_req[1].cyc && m_req[1].stb)) &&
        (!m_rsp[2].ack || (m_req[2].cyc && m_req[2].stb)))
    else
    begin
        $error("ack reached more than one master or a master without a strobe");
        fail_count++;
    end

    // ==============================
    // Ring indices
    // ==============================

    // A fetch only targets a slot the host has already published
    fetch_behind_host: assert property (@(posedge clk) disable iff (reset)
        m_req[1].cyc |-> fetch_idx != cfg.in_newest[ring_idx_bits-1:0])
    else
    begin
        $error("reader fetch index ran past the host produced index");
        fail_count++;
    end

    // Advancing onto the host's consumed index would make a full ring look empty
    writer_not_past_full: assert property (@(posedge clk) disable iff (reset)
        out_newest != $past(out_newest) |->
            out_newest != $past(cfg.out_oldest[ring_idx_bits-1:0]))
    else
    begin
        $error("writer advanced its produced index onto the consumed index");
        fail_count++;
    end

endmodule

bind ring_channel_top ring_channel_asserts #(.ring_idx_bits(ring_idx_bits)) u_asserts
    (.clk, .reset, .mem_req, .mem_rsp, .m_req, .m_rsp, .cfg,
     .fetch_idx(u_reader.fetch_idx), .out_newest);

// File: verification/ring_channel_tb.sv
// Ring channel testbench
// Directed tests of the inbound and outbound rings through the host port
// and the device streams, checked against a model of both ring indices

`timescale 1ns/10ps

module ring_channel_tb;

    localparam int ring_idx_bits = 4;
    localparam int ring_size     = 1 << ring_idx_bits;
    localparam int cycle_limit   = 4000;

    // Bases are deliberately unaligned
    localparam logic [11:0] in_ring_base  = 12'h105;
    localparam logic [11:0] out_ring_base = 12'h2a3;

    logic                        clk = 1'b0;
    logic                        reset;
    ring_pkg::wb_req_t           host_req;
    ring_pkg::wb_rsp_t           host_rsp;
    ring_pkg::ring_cfg_t         cfg;
    ring_pkg::ring_status_t      status;
    logic [ring_pkg::data_w-1:0] rx_data;
    logic                        rx_valid;
    logic                        rx_ready;
    logic [ring_pkg::data_w-1:0] tx_data;
    logic                        tx_valid;
    logic                        tx_ready;

    integer seed   = 15256;
    int     errors = 0;
    int     checks = 0;
    int     tests  = 0;
    int     cycles = 0;

    // Ring model counts of inbound words produced and outbound words accepted and consumed
    int in_head;
    int out_head;
    int out_tail;
    logic [31:0] rx_exp [$];
    logic [31:0] tx_exp [$];

    always #2 clk = ~clk;

    ring_channel_top #(.ring_idx_bits(ring_idx_bits)) dut0
        (.clk, .reset, .host_req, .host_rsp, .cfg, .status,
         .rx_data, .rx_valid, .rx_ready, .tx_data, .tx_valid, .tx_ready);

    // ==============================
    // Helpers
    // ==============================

    // Every task resumes 1 ns after a rising edge, where inputs are driven
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int first_error);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - first_error);
    endtask

    // One Wishbone classic access followed by one idle cycle so the arbiter can rotate
    task automatic host_access(input logic we, input logic [11:0] adr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
        do
            tick();
        while (!host_rsp.ack);
        rdata = host_rsp.dat_r;
        // The strobe stays up through the ack cycle and drops in the cycle after it
        tick();
        host_req = '0;
        tick();
    endtask

    task automatic host_write(input logic [11:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        host_access(1'b1, adr, data, unused);
    endtask

    task automatic host_read(input logic [11:0] adr, output logic [31:0] data);
        host_access(1'b0, adr, '0, data);
    endtask

    // Host fills the next inbound slot and leaves publishing to the caller
    task automatic produce_in(input logic [31:0] data);
        host_write(in_ring_base + 12'(in_head % ring_size), data);
        rx_exp.push_back(data);
        in_head++;
    endtask

    // Host drains the oldest outbound slot and compares it with the model
    task automatic consume_out();
        logic [31:0] data;
        host_read(out_ring_base + 12'(out_tail % ring_size), data);
        check_val("outbound slot", data, tx_exp.pop_front());
        out_tail++;
    endtask

    task automatic send_tx(input logic [31:0] data);
        logic ready;
        tx_data  = data;
        tx_valid = 1'b1;
        do
        begin
            #1;
            ready = tx_ready;
            tick();
        end
        while (!ready);
        tx_valid = 1'b0;
        tx_exp.push_back(data);
        out_head++;
    endtask

    // With stall set, rx_ready toggles at random to stress the output queue
    task automatic expect_rx(input int count, input bit stall);
        int          got;
        logic        taken;
        logic [31:0] data;
        got = 0;
        while (got < count)
        begin
            rx_ready = stall ? 1'($random(seed)) : 1'b1;
            #1;
            taken = rx_valid && rx_ready;
            data  = rx_data;
            tick();
            if (taken)
            begin
                assert (rx_exp.size() != 0)
                else
                begin
                    $display("rx delivered word 0x%h while none was outstanding", data);
                    errors++;
                end
                if (rx_exp.size() != 0)
                    check_val("rx_data", data, rx_exp.pop_front());
                got++;
            end
        end
        rx_ready = 1'b0;
    endtask

    task automatic wait_out_newest(input int count);
        while (status.out_newest != 8'(count % ring_size))
            tick();
    endtask

    // Host side of the concurrent test refills inbound and drains outbound
    task automatic host_traffic(input int n_in, input int n_out);
        int produced;
        int consumed;
        bit busy;
        produced = 0;
        consumed = 0;
        while (produced < n_in || consumed < n_out)
        begin
            busy = 1'b0;
            // One slot stays empty so the host never overruns the reader
            if (produced < n_in && ((in_head + 1) % ring_size) != status.in_oldest)
            begin
                produce_in($random(seed));
                cfg.in_newest = 8'(in_head);
                produced++;
                busy = 1'b1;
            end
            if (consumed < n_out && status.out_newest != 8'(out_tail % ring_size))
            begin
                consume_out();
                cfg.out_oldest = 8'(out_tail);
                consumed++;
                busy = 1'b1;
            end
            if (!busy)
                tick();
        end
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_val("rx_valid", rx_valid, 1'b0);
        check_val("tx_ready", tx_ready, 1'b1);
        check_val("status.in_oldest", status.in_oldest, 0);
        check_val("status.out_newest", status.out_newest, 0);
        report("reset", e0);
    endtask

    task automatic test_inbound();
        int e0;
        e0 = errors;
        for (int k = 0; k < 5; k++)
            produce_in($random(seed));
        cfg.in_newest = 8'(in_head);
        expect_rx(5, 1'b0);
        check_val("status.in_oldest", status.in_oldest, in_head % ring_size);
        report("inbound", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int start;
        e0       = errors;
        start    = in_head;
        rx_ready = 1'b0;
        for (int k = 0; k < 4; k++)
            produce_in($random(seed));
        cfg.in_newest = 8'(in_head);
        while (!rx_valid)
            tick();
        // Let the reader fill its queue and stall
        repeat (20)
            tick();
        check_val("status.in_oldest", status.in_oldest, start % ring_size);
        expect_rx(4, 1'b0);
        check_val("status.in_oldest", status.in_oldest, in_head % ring_size);
        report("backpressure", e0);
    endtask

    task automatic test_outbound();
        int e0;
        e0 = errors;
        for (int k = 0; k < 6; k++)
            send_tx($random(seed));
        wait_out_newest(out_head);
        for (int k = 0; k < 6; k++)
            consume_out();
        cfg.out_oldest = 8'(out_tail);
        report("outbound", e0);
    endtask

    task automatic test_full();
        int e0;
        e0 = errors;
        for (int k = 0; k < ring_size - 1; k++)
            send_tx($random(seed));
        wait_out_newest(out_head);
        // A sixteenth word is offered and must be held off
        tx_data  = $random(seed);
        tx_valid = 1'b1;
        repeat (12)
        begin
            #1;
            check_val("tx_ready", tx_ready, 1'b0);
            tick();
        end
        check_val("status.out_newest", status.out_newest, out_head % ring_size);
        for (int k = 0; k < ring_size - 1; k++)
            consume_out();
        cfg.out_oldest = 8'(out_tail);
        send_tx(tx_data);
        wait_out_newest(out_head);
        consume_out();
        cfg.out_oldest = 8'(out_tail);
        report("full", e0);
    endtask

    task automatic test_concurrent();
        int e0;
        e0 = errors;
        fork
            host_traffic(24, 24);
            expect_rx(24, 1'b1);
            begin
                for (int k = 0; k < 24; k++)
                begin
                    send_tx($random(seed));
                    repeat ($random(seed) & 3)
                        tick();
                end
            end
        join
        check_val("status.in_oldest", status.in_oldest, in_head % ring_size);
        check_val("status.out_newest", status.out_newest, out_head % ring_size);
        report("concurrent", e0);
    endtask

    // ==============================
    // Sequence and timeout
    // ==============================

    initial
    begin
        int assert_fails;
        reset    = 1'b1;
        host_req = '0;
        cfg      = '{in_base: in_ring_base, out_base: out_ring_base,
                     in_newest: 8'd0, out_oldest: 8'd0};
        rx_ready = 1'b0;
        tx_data  = '0;
        tx_valid = 1'b0;
        in_head  = 0;
        out_head = 0;
        out_tail = 0;
        repeat (16)
            @(posedge clk);
        #1;
        reset = 1'b0;
        tick();
        test_reset();
        test_inbound();
        test_backpressure();
        test_outbound();
        test_full();
        test_concurrent();
        assert_fails = dut0.u_asserts.fail_count;
        $display("Summary: %0d tests, %0d checks, %0d check errors, %0d assertion failures",
                 tests, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // Limit covers six tests of up to about 40 accesses at 8 cycles each
    initial
    begin
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: tests did not finish within %0d clock cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: build.f
src/ring_pkg.sv
src/ring_reader.sv
src/ring_writer.sv
src/mem_arbiter.sv
src/shared_mem.sv
src/ring_channel_top.sv
verification/ring_channel_asserts.sv
verification/ring_channel_tb.sv

// File: Bender.yml
package:
  name: ring_channel

sources:
  - files:
      - src/ring_pkg.sv
      - src/ring_reader.sv
      - src/ring_writer.sv
      - src/mem_arbiter.sv
      - src/shared_mem.sv
      - src/ring_channel_top.sv
  - target: test
    files:
      - verification/ring_channel_asserts.sv
      - verification/ring_channel_tb.sv
